// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qxF 'All tests passed!'

clean:
	rm -rf $(OBJ_DIR)

// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // first fetch address after reset
    localparam logic [31:0] reset_pc = 32'hbfc00000;

    // primary opcodes
    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // funct field under op_special
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,
        alu_lui
    } alu_op_e;

    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm16;
    } i_fmt_t;

    // one instruction word, two field layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    typedef struct packed {
        logic [31:0] pc;
    } fs_ds_t;

    typedef struct packed {
        logic [31:0] pc;
        alu_op_e     alu_op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [31:0] store_data;
        logic        mem_re;
        logic        mem_we;
        logic [4:0]  dest;
    } ds_es_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic        mem_re;
        logic [4:0]  dest;
    } es_ms_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] value;
        logic [4:0]  dest;
    } ms_ws_t;

    // pending register write, dest 0 means none
    typedef struct packed {
        logic [4:0]  dest;
        logic [31:0] value;
    } fwd_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_t;

endpackage

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic        clk,
    input  logic        rst_n,
    // instruction sram
    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,
    // data sram
    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,
    // register write trace
    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);
    import cpu_pkg::*;

    br_t  br;
    fwd_t es_fwd;
    fwd_t ms_fwd;
    fwd_t ws_fwd;
    logic es_load;

    stage_link #(.payload_t(fs_ds_t)) fs_ds ();
    stage_link #(.payload_t(ds_es_t)) ds_es ();
    stage_link #(.payload_t(es_ms_t)) es_ms ();
    stage_link #(.payload_t(ms_ws_t)) ms_ws ();

    // fetch only reads
    assign inst_sram_wen   = 4'h0;
    assign inst_sram_wdata = 32'd0;

    if_stage u_if_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .br             (br),
        .to_ds          (fs_ds.sender),
        .inst_sram_en   (inst_sram_en),
        .inst_sram_addr (inst_sram_addr)
    );

    id_stage u_id_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_sram_rdata (inst_sram_rdata),
        .from_fs         (fs_ds.receiver),
        .to_es           (ds_es.sender),
        .br              (br),
        .es_fwd          (es_fwd),
        .ms_fwd          (ms_fwd),
        .ws_fwd          (ws_fwd),
        .es_load         (es_load)
    );

    exe_stage u_exe_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .from_ds         (ds_es.receiver),
        .to_ms           (es_ms.sender),
        .fwd             (es_fwd),
        .es_load         (es_load),
        .data_sram_en    (data_sram_en),
        .data_sram_wen   (data_sram_wen),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    mem_stage u_mem_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .data_sram_rdata (data_sram_rdata),
        .from_es         (es_ms.receiver),
        .to_ws           (ms_ws.sender),
        .fwd             (ms_fwd)
    );

    wb_stage u_wb_stage (
        .clk               (clk),
        .rst_n             (rst_n),
        .from_ms           (ms_ws.receiver),
        .fwd               (ws_fwd),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// File: exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  logic          clk,
    input  logic          rst_n,
    stage_link.receiver   from_ds,
    stage_link.sender     to_ms,
    output cpu_pkg::fwd_t fwd,
    output logic          es_load,
    output logic          data_sram_en,
    output logic [3:0]    data_sram_wen,
    output logic [31:0]   data_sram_addr,
    output logic [31:0]   data_sram_wdata
);
    import cpu_pkg::*;

    logic        es_valid;
    ds_es_t      es_data;
    logic [31:0] result;

    assign from_ds.allowin = !es_valid || to_ms.allowin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            es_valid <= 1'b0;
        end else if (from_ds.allowin) begin
            es_valid <= from_ds.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_ds.valid && from_ds.allowin) begin
            es_data <= from_ds.payload;
        end
    end

    always_comb begin
        case (es_data.alu_op)
            alu_sub: result = es_data.src_a - es_data.src_b;
            alu_and: result = es_data.src_a & es_data.src_b;
            alu_or:  result = es_data.src_a | es_data.src_b;
            alu_slt: result = {31'd0, $signed(es_data.src_a) < $signed(es_data.src_b)};
            // shift amount rides in src_a
            alu_sll: result = es_data.src_b << es_data.src_a[4:0];
            alu_lui: result = {es_data.src_b[15:0], 16'd0};
            default: result = es_data.src_a + es_data.src_b;
        endcase
    end

    // load and store address is the add result
    assign data_sram_en    = es_valid && (es_data.mem_re || es_data.mem_we);
    assign data_sram_wen   = (es_valid && es_data.mem_we) ? 4'hf : 4'h0;
    assign data_sram_addr  = result;
    assign data_sram_wdata = es_data.store_data;

    // a load's dest stays visible so decode can detect load-use
    assign es_load   = es_valid && es_data.mem_re;
    assign fwd.dest  = es_valid ? es_data.dest : 5'd0;
    assign fwd.value = result;

    assign to_ms.valid   = es_valid;
    assign to_ms.payload = '{pc: es_data.pc, result: result, mem_re: es_data.mem_re,
                             dest: es_data.dest};

    // read data comes back while the instruction sits in memory
    a_req_moves: assert property (@(posedge clk) disable iff (!rst_n)
        data_sram_en |-> es_valid && to_ms.allowin)
        else $error("data sram request without a moving instruction");

endmodule

`default_nettype wire

// File: files.f
cpu_pkg.sv
stage_link.sv
if_stage.sv
id_stage.sv
exe_stage.sv
mem_stage.sv
wb_stage.sv
cpu_top.sv
tb_cpu_top.sv

// File: id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  logic [31:0]   inst_sram_rdata,
    stage_link.receiver   from_fs,
    stage_link.sender     to_es,
    output cpu_pkg::br_t  br,
    input  cpu_pkg::fwd_t es_fwd,
    input  cpu_pkg::fwd_t ms_fwd,
    input  cpu_pkg::fwd_t ws_fwd,
    input  logic          es_load
);
    import cpu_pkg::*;

    logic        ds_valid;
    logic [31:0] ds_pc;
    instr_u      ds_inst;
    logic [31:0] rf [32];
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [31:0] rs_val;
    logic [31:0] rt_val;
    logic [31:0] imm_sext;
    logic [31:0] pc_plus4;
    logic        rs_used;
    logic        rt_used;
    logic        load_use;
    logic        ready_go;
    alu_op_e     alu_op;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic        mem_re;
    logic        mem_we;
    logic [4:0]  dest;
    logic        br_cond;
    logic [31:0] br_target;

    // nearest pending write wins, $0 is always zero
    function automatic logic [31:0] operand(input logic [4:0] idx, input logic [31:0] rf_val,
                                            input fwd_t e, input fwd_t m, input fwd_t w);
        if (idx == 5'd0) return 32'd0;
        if (e.dest == idx) return e.value;
        if (m.dest == idx) return m.value;
        if (w.dest == idx) return w.value;
        return rf_val;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ds_valid <= 1'b0;
        end else if (from_fs.allowin) begin
            ds_valid <= from_fs.valid;
        end
    end

    // word is latched on entry, sram output moves on afterwards
    always_ff @(posedge clk) begin
        if (from_fs.valid && from_fs.allowin) begin
            ds_pc   <= from_fs.payload.pc;
            ds_inst <= inst_sram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (ws_fwd.dest != 5'd0) begin
            rf[ws_fwd.dest] <= ws_fwd.value;
        end
    end

    assign rs       = ds_inst.r_fmt.rs;
    assign rt       = ds_inst.i_fmt.rt;
    assign rs_val   = operand(rs, rf[rs], es_fwd, ms_fwd, ws_fwd);
    assign rt_val   = operand(rt, rf[rt], es_fwd, ms_fwd, ws_fwd);
    assign imm_sext = {{16{ds_inst.i_fmt.imm16[15]}}, ds_inst.i_fmt.imm16};
    assign pc_plus4 = ds_pc + 32'd4;

    always_comb begin
        alu_op    = alu_add;
        src_a     = rs_val;
        src_b     = rt_val;
        mem_re    = 1'b0;
        mem_we    = 1'b0;
        dest      = 5'd0;
        rs_used   = 1'b0;
        rt_used   = 1'b0;
        br_cond   = 1'b0;
        br_target = pc_plus4 + {imm_sext[29:0], 2'b00};
        case (ds_inst.r_fmt.opcode)
            op_special: begin
                rs_used = 1'b1;
                rt_used = 1'b1;
                dest    = ds_inst.r_fmt.rd;
                case (ds_inst.r_fmt.funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_slt:  alu_op = alu_slt;
                    fn_sll: begin
                        alu_op  = alu_sll;
                        src_a   = {27'd0, ds_inst.r_fmt.shamt};
                        rs_used = 1'b0;
                    end
                    default: dest = 5'd0;
                endcase
            end
            op_addiu, op_lui, op_lw: begin
                rs_used = ds_inst.r_fmt.opcode != op_lui;
                alu_op  = (ds_inst.r_fmt.opcode == op_lui) ? alu_lui : alu_add;
                src_b   = imm_sext;
                mem_re  = ds_inst.r_fmt.opcode == op_lw;
                dest    = rt;
            end
            op_sw: begin
                rs_used = 1'b1;
                rt_used = 1'b1;
                src_b   = imm_sext;
                mem_we  = 1'b1;
            end
            op_beq, op_bne: begin
                rs_used = 1'b1;
                rt_used = 1'b1;
                br_cond = (rs_val == rt_val) ^ (ds_inst.r_fmt.opcode == op_bne);
            end
            op_j: begin
                br_cond   = 1'b1;
                br_target = {pc_plus4[31:28], ds_inst.i_fmt.rs, rt, ds_inst.i_fmt.imm16, 2'b00};
            end
            default: ;
        endcase
    end

    // loaded value is not ready until memory, hold one cycle
    assign load_use = es_load && es_fwd.dest != 5'd0
                      && ((rs_used && es_fwd.dest == rs) || (rt_used && es_fwd.dest == rt));
    assign ready_go = !load_use;

    assign from_fs.allowin = !ds_valid || (ready_go && to_es.allowin);
    assign to_es.valid     = ds_valid && ready_go;
    assign to_es.payload   = '{pc: ds_pc, alu_op: alu_op, src_a: src_a, src_b: src_b,
                               store_data: rt_val, mem_re: mem_re, mem_we: mem_we,
                               dest: dest};

    assign br.taken  = ds_valid && ready_go && br_cond;
    assign br.target = br_target;

    // redirect only once the delay slot sits in fetch
    a_delay_slot: assert property (@(posedge clk) disable iff (!rst_n)
        br.taken |-> ds_valid && from_fs.valid)
        else $error("branch taken without its delay slot in fetch");

endmodule

`default_nettype wire

// File: if_stage.sv
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  cpu_pkg::br_t  br,
    stage_link.sender     to_ds,
    output logic          inst_sram_en,
    output logic [31:0]   inst_sram_addr
);
    import cpu_pkg::*;

    logic [31:0] pc;
    logic [31:0] next_pc;
    logic        fs_valid;
    logic        fetch_on;

    // delay slot is already here when decode resolves a branch
    assign next_pc = br.taken ? br.target : pc + 32'd4;

    // no request while decode holds, so the sram keeps the old word
    assign inst_sram_en   = fetch_on & to_ds.allowin;
    assign inst_sram_addr = next_pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_on <= 1'b0;
            fs_valid <= 1'b0;
            pc       <= reset_pc - 32'd4;
        end else begin
            fetch_on <= 1'b1;
            if (inst_sram_en) begin
                pc       <= next_pc;
                fs_valid <= 1'b1;
            end else if (to_ds.allowin) begin
                fs_valid <= 1'b0;
            end
        end
    end

    assign to_ds.valid   = fs_valid;
    assign to_ds.payload = '{pc: pc};

endmodule

`default_nettype wire

// File: mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic          clk,
    input  logic          rst_n,
    input  logic [31:0]   data_sram_rdata,
    stage_link.receiver   from_es,
    stage_link.sender     to_ws,
    output cpu_pkg::fwd_t fwd
);
    import cpu_pkg::*;

    logic        ms_valid;
    es_ms_t      ms_data;
    logic [31:0] value;

    assign from_es.allowin = !ms_valid || to_ws.allowin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ms_valid <= 1'b0;
        end else if (from_es.allowin) begin
            ms_valid <= from_es.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_es.valid && from_es.allowin) begin
            ms_data <= from_es.payload;
        end
    end

    // sram answers in this cycle for a load
    assign value = ms_data.mem_re ? data_sram_rdata : ms_data.result;

    assign fwd.dest  = ms_valid ? ms_data.dest : 5'd0;
    assign fwd.value = value;

    assign to_ws.valid   = ms_valid;
    assign to_ws.payload = '{pc: ms_data.pc, value: value, dest: ms_data.dest};

endmodule

`default_nettype wire

// File: stage_link.sv
`timescale 1ns/1ps
`default_nettype none

// one pipeline hand-off, moves on valid && allowin
interface stage_link #(
    parameter type payload_t = logic
);

    logic     valid;
    logic     allowin;
    payload_t payload;

    modport sender (
        output valid,
        output payload,
        input  allowin
    );

    modport receiver (
        input  valid,
        input  payload,
        output allowin
    );

endinterface

`default_nettype wire

// File: tb_cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_top;
    import cpu_pkg::*;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        inst_sram_en;
    logic [3:0]  inst_sram_wen;
    logic [31:0] inst_sram_addr;
    logic [31:0] inst_sram_wdata;
    logic [31:0] inst_sram_rdata = 32'd0;
    logic        data_sram_en;
    logic [3:0]  data_sram_wen;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata = 32'd0;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    logic [31:0] exp_dmem [256];
    logic [31:0] prog [256];
    logic [31:0] model_rf [32];
    int          prog_len;
    logic [31:0] got_pc [$];
    logic [31:0] got_num [$];
    logic [31:0] got_data [$];
    logic [31:0] got_wen [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_num [$];
    logic [31:0] exp_data [$];
    logic [31:0] first_fetch;
    logic        fetch_seen;
    logic [3:0]  inst_wen_seen;
    logic [31:0] inst_wdata_seen;
    int          errors;
    int          budget = 10;
    int          run_cycles;

    cpu_top u_cpu_top (.*);

    always #4 clk = ~clk;

    // instruction sram, one cycle read latency, nop outside the program window
    always @(posedge clk) begin
        if (inst_sram_en) begin
            inst_sram_rdata <= ((inst_sram_addr - reset_pc) < 32'd1024) ?
                               imem[inst_sram_addr[9:2]] : 32'd0;
        end
    end

    function automatic logic [31:0] fill_word(input int i);
        return {8'hd0, 8'(i), ~8'(i), 8'h3c};
    endfunction

    // data sram, image restored during every reset
    always @(posedge clk) begin
        if (!rst_n) begin
            foreach (dmem[i]) dmem[i] <= fill_word(i);
        end else if (data_sram_en) begin
            if (data_sram_wen == 4'hf) begin
                dmem[data_sram_addr[9:2]] <= data_sram_wdata;
            end
            data_sram_rdata <= dmem[data_sram_addr[9:2]];
        end
    end

    // trace, first fetch and inst sram write port capture
    always @(negedge clk) begin
        if (rst_n) begin
            if (inst_sram_en && !fetch_seen) begin
                first_fetch = inst_sram_addr;
                fetch_seen  = 1'b1;
            end
            inst_wen_seen   = inst_wen_seen | inst_sram_wen;
            inst_wdata_seen = inst_wdata_seen | inst_sram_wdata;
            if (debug_wb_rf_wen != 4'h0) begin
                got_pc.push_back(debug_wb_pc);
                got_num.push_back({27'd0, debug_wb_rf_wnum});
                got_data.push_back(debug_wb_rf_wdata);
                got_wen.push_back({28'd0, debug_wb_rf_wen});
            end
        end
    end

    function automatic logic [31:0] r_word(input logic [5:0] funct, input int rd, input int rs,
                                           input int rt, input int sh);
        return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input int rt, input int rs,
                                           input int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    // jump to a program word index
    function automatic logic [31:0] j_word(input int index);
        logic [31:0] target;
        target = reset_pc + 32'(index * 4);
        return {op_j, target[27:2]};
    endfunction

    function automatic void add_instr(input logic [31:0] word);
        prog[8'(prog_len)] = word;
        prog_len++;
    endfunction

    // instruction level model with one delay slot
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] tgt;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] val;
        logic [4:0]  dst;
        int          steps;
        foreach (model_rf[i]) model_rf[i] = 32'd0;
        pc    = reset_pc;
        npc   = reset_pc + 32'd4;
        steps = 0;
        while ((pc - reset_pc) < 32'(prog_len * 4) && steps < 1000) begin
            w    = prog[pc[9:2]];
            a    = model_rf[w[25:21]];
            b    = model_rf[w[20:16]];
            sext = {{16{w[15]}}, w[15:0]};
            addr = a + sext;
            tgt  = npc + 32'd4;
            dst  = 5'd0;
            val  = 32'd0;
            case (w[31:26])
                op_special: begin
                    dst = w[15:11];
                    case (w[5:0])
                        fn_addu: val = a + b;
                        fn_subu: val = a - b;
                        fn_and:  val = a & b;
                        fn_or:   val = a | b;
                        fn_slt:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        fn_sll:  val = b << w[10:6];
                        default: dst = 5'd0;
                    endcase
                end
                op_addiu: begin
                    dst = w[20:16];
                    val = a + sext;
                end
                op_lui: begin
                    dst = w[20:16];
                    val = {w[15:0], 16'd0};
                end
                op_lw: begin
                    dst = w[20:16];
                    val = exp_dmem[addr[9:2]];
                end
                op_sw:  exp_dmem[addr[9:2]] = b;
                op_beq: if (a == b) tgt = npc + {sext[29:0], 2'b00};
                op_bne: if (a != b) tgt = npc + {sext[29:0], 2'b00};
                op_j:   tgt = {npc[31:28], w[25:0], 2'b00};
                default: ;
            endcase
            if (dst != 5'd0) begin
                model_rf[dst] = val;
                exp_pc.push_back(pc);
                exp_num.push_back({27'd0, dst});
                exp_data.push_back(val);
            end
            pc  = npc;
            npc = tgt;
            steps++;
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error: %s %s expected %h actual %h", test, what, expected, actual);
        end
    endtask

    task automatic run_and_check(input string name);
        int waited;
        int limit;
        limit  = 20 * prog_len;
        // reset, drain and slack on top of the program allowance
        budget += limit + 30;
        @(posedge clk);
        rst_n <= 1'b0;
        @(posedge clk);
        foreach (imem[i]) imem[i] = (i < prog_len) ? prog[i] : 32'd0;
        foreach (exp_dmem[i]) exp_dmem[i] = fill_word(i);
        got_pc.delete();
        got_num.delete();
        got_data.delete();
        got_wen.delete();
        exp_pc.delete();
        exp_num.delete();
        exp_data.delete();
        fetch_seen      = 1'b0;
        inst_wen_seen   = 4'h0;
        inst_wdata_seen = 32'd0;
        run_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (inst_sram_en !== 1'b0 || debug_wb_rf_wen !== 4'h0) begin
            errors++;
            $display("%s: sram request or trace write seen while in reset", name);
        end
        @(posedge clk);
        rst_n <= 1'b1;
        waited = 0;
        while (got_pc.size() < exp_pc.size() && waited < limit) begin
            @(posedge clk);
            waited++;
        end
        if (got_pc.size() < exp_pc.size()) begin
            errors++;
            $display("%s: only %0d of %0d register writes retired in time",
                     name, got_pc.size(), exp_pc.size());
        end
        // let trailing stores land and catch any extra writes
        repeat (10) @(posedge clk);
        if (!fetch_seen) begin
            errors++;
            $display("%s: no instruction fetch after reset", name);
        end else begin
            check_value(name, "first fetch", reset_pc, first_fetch);
        end
        check_value(name, "inst sram wen", 32'd0, {28'd0, inst_wen_seen});
        check_value(name, "inst sram wdata", 32'd0, inst_wdata_seen);
        check_value(name, "write count", 32'(exp_pc.size()), 32'(got_pc.size()));
        for (int i = 0; i < exp_pc.size(); i++) begin
            if (i < got_pc.size()) begin
                check_value(name, $sformatf("write %0d pc", i), exp_pc[i], got_pc[i]);
                check_value(name, $sformatf("write %0d reg", i), exp_num[i], got_num[i]);
                check_value(name, $sformatf("write %0d data", i), exp_data[i], got_data[i]);
                check_value(name, $sformatf("write %0d wen", i), 32'hf, got_wen[i]);
            end
        end
        foreach (exp_dmem[i]) begin
            check_value(name, $sformatf("data word %0d", i), exp_dmem[i], dmem[i]);
        end
    endtask

    task automatic test_reset();
        prog_len = 0;
        add_instr(i_word(op_addiu, 1, 0, 5));
        add_instr(i_word(op_addiu, 2, 1, -3));
        add_instr(r_word(fn_addu, 3, 1, 2, 0));
        run_and_check("reset");
    endtask

    task automatic test_alu();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = $urandom();
        b = $urandom();
        c = $urandom();
        prog_len = 0;
        add_instr(i_word(op_lui, 1, 0, int'(a[31:16])));
        add_instr(i_word(op_addiu, 1, 1, int'(a[15:0])));
        add_instr(i_word(op_lui, 2, 0, int'(b[31:16])));
        add_instr(i_word(op_addiu, 2, 2, int'(b[15:0])));
        // operands come from execute, memory and writeback
        add_instr(r_word(fn_addu, 3, 1, 2, 0));
        add_instr(r_word(fn_subu, 4, 3, 1, 0));
        add_instr(r_word(fn_and, 5, 4, 3, 0));
        add_instr(r_word(fn_or, 6, 5, 2, 0));
        add_instr(r_word(fn_slt, 7, 4, 6, 0));
        add_instr(r_word(fn_sll, 8, 0, 6, int'(c[4:0])));
        add_instr(r_word(fn_slt, 9, 6, 4, 0));
        add_instr(r_word(fn_addu, 0, 1, 2, 0));
        add_instr(r_word(fn_addu, 10, 0, 8, 0));
        add_instr(i_word(op_addiu, 11, 10, int'(c[20:5])));
        add_instr(r_word(fn_subu, 12, 11, 0, 0));
        run_and_check("alu");
    endtask

    task automatic test_memory();
        logic [31:0] a;
        logic [31:0] b;
        a = $urandom();
        b = $urandom();
        prog_len = 0;
        add_instr(i_word(op_addiu, 1, 0, 'h40));
        add_instr(i_word(op_lui, 2, 0, int'(a[31:16])));
        add_instr(i_word(op_addiu, 2, 2, int'(a[15:0])));
        add_instr(i_word(op_lui, 3, 0, int'(b[31:16])));
        add_instr(i_word(op_addiu, 3, 3, int'(b[15:0])));
        add_instr(i_word(op_sw, 2, 1, 0));
        add_instr(i_word(op_sw, 3, 1, 4));
        add_instr(i_word(op_sw, 3, 1, 'h80));
        add_instr(i_word(op_addiu, 4, 1, 'h100));
        add_instr(i_word(op_sw, 2, 4, -8));
        add_instr(i_word(op_lw, 5, 1, 4));
        add_instr(i_word(op_lw, 6, 1, 0));
        add_instr(i_word(op_lw, 7, 1, 'h80));
        add_instr(i_word(op_lw, 8, 1, 'h10));
        add_instr(i_word(op_lw, 9, 4, -8));
        add_instr(i_word(op_addiu, 10, 9, 1));
        run_and_check("memory");
    endtask

    task automatic test_load_use();
        logic [31:0] a;
        a = $urandom();
        prog_len = 0;
        add_instr(i_word(op_addiu, 1, 0, 'h200));
        add_instr(i_word(op_lui, 2, 0, int'(a[31:16])));
        add_instr(i_word(op_addiu, 2, 2, int'(a[15:0])));
        add_instr(i_word(op_sw, 2, 1, 8));
        add_instr(i_word(op_lw, 3, 1, 8));
        add_instr(r_word(fn_addu, 4, 3, 2, 0));
        add_instr(i_word(op_lw, 5, 1, 8));
        add_instr(r_word(fn_addu, 6, 1, 5, 0));
        add_instr(i_word(op_lw, 7, 1, 'h24));
        add_instr(r_word(fn_subu, 8, 7, 6, 0));
        add_instr(i_word(op_lw, 9, 1, 0));
        add_instr(i_word(op_sw, 9, 1, 12));
        add_instr(i_word(op_lw, 10, 1, 12));
        add_instr(i_word(op_addiu, 11, 10, 1));
        run_and_check("load_use");
    endtask

    task automatic test_branch();
        prog_len = 0;
        add_instr(i_word(op_addiu, 1, 0, 7));
        add_instr(i_word(op_addiu, 2, 0, 7));
        add_instr(i_word(op_beq, 2, 1, 2));
        add_instr(i_word(op_addiu, 3, 0, 1));
        add_instr(i_word(op_addiu, 4, 0, 2));
        add_instr(i_word(op_bne, 2, 1, 2));
        add_instr(i_word(op_addiu, 5, 0, 3));
        add_instr(i_word(op_addiu, 6, 0, 4));
        add_instr(i_word(op_bne, 6, 1, 2));
        add_instr(i_word(op_addiu, 7, 1, 1));
        add_instr(i_word(op_addiu, 8, 0, 9));
        add_instr(i_word(op_beq, 6, 1, 5));
        add_instr(i_word(op_addiu, 9, 0, 5));
        add_instr(j_word(16));
        add_instr(r_word(fn_addu, 10, 9, 7, 0));
        add_instr(i_word(op_addiu, 11, 0, 6));
        add_instr(i_word(op_addiu, 12, 10, 1));
        add_instr(i_word(op_addiu, 13, 12, 2));
        run_and_check("branch");
    endtask

    initial begin : watchdog
        run_cycles = 0;
        while (run_cycles <= budget) begin
            @(posedge clk);
            run_cycles++;
        end
        $display("timeout: simulation still running after %0d cycles", run_cycles);
        $display("Test failures found");
        $finish;
    end

    initial begin
        errors = 0;
        void'($urandom(77));
        test_reset();
        test_alu();
        test_memory();
        test_load_use();
        test_branch();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage (
    input  logic          clk,
    input  logic          rst_n,
    stage_link.receiver   from_ms,
    output cpu_pkg::fwd_t fwd,
    output logic [31:0]   debug_wb_pc,
    output logic [3:0]    debug_wb_rf_wen,
    output logic [4:0]    debug_wb_rf_wnum,
    output logic [31:0]   debug_wb_rf_wdata
);
    import cpu_pkg::*;

    logic   ws_valid;
    ms_ws_t ws_data;

    // last stage, retires every cycle
    assign from_ms.allowin = 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= from_ms.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (from_ms.valid) begin
            ws_data <= from_ms.payload;
        end
    end

    // same write feeds the register file and the bypass
    assign fwd.dest  = ws_valid ? ws_data.dest : 5'd0;
    assign fwd.value = ws_data.value;

    assign debug_wb_pc       = ws_data.pc;
    assign debug_wb_rf_wen   = (fwd.dest != 5'd0) ? 4'hf : 4'h0;
    assign debug_wb_rf_wnum  = ws_data.dest;
    assign debug_wb_rf_wdata = ws_data.value;

    // every traced write was handed over by memory a cycle earlier
    a_trace_src: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_wen != 4'h0 |-> $past(from_ms.valid))
        else $error("trace write with writeback empty");

endmodule

`default_nettype wire
